//--- source/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Opcode field
`define OP_RTYPE 6'b000000
`define OP_J     6'b000010
`define OP_JAL   6'b000011
`define OP_BEQ   6'b000100
`define OP_BNE   6'b000101
`define OP_ORI   6'b001101
`define OP_LUI   6'b001111
`define OP_LW    6'b100011
`define OP_SW    6'b101011

// Function field of R-type
`define FN_SLL   6'b000000
`define FN_JR    6'b001000
`define FN_ADDU  6'b100001
`define FN_SUBU  6'b100011
`define FN_AND   6'b100100
`define FN_OR    6'b100101
`define FN_SLT   6'b101010

`define RESET_PC  32'h0000_3000
`define REG_COUNT 32

`endif

//--- source/mipsPkg.sv
`default_nettype none

package mipsPkg;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFmt_t;

    // One word, two views; jump target sits in bits 25:0
    typedef union packed {
        rFmt_t rFmt;
        iFmt_t iFmt;
    } instrWord_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL, ALU_LUI
    } aluOp_t;

    typedef enum logic [1:0] {DST_RD, DST_RT, DST_RA} destSel_t;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC8} wbSel_t;
    typedef enum logic [2:0] {BR_NONE, BR_BEQ, BR_BNE, BR_J, BR_JAL, BR_JR} branchKind_t;
    typedef enum logic [1:0] {FWD_RF, FWD_EX, FWD_MEM, FWD_WB} fwdSel_t;

    typedef struct packed {
        aluOp_t      aluOp;
        logic        aluSrcImm;   // B from immediate
        logic        aluSrcShamt; // A from shamt
        logic        extSigned;
        logic        regWrite;
        destSel_t    destSel;
        wbSel_t      wbSel;
        logic        memRead;
        logic        memWrite;
        branchKind_t branchKind;
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        instrWord_t  instr;
    } fdReg_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        instrWord_t  instr;
        ctrl_t       ctrl;
        logic [31:0] opA;
        logic [31:0] opB;
        logic [31:0] imm;
        logic [4:0]  dest;
    } deReg_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        instrWord_t  instr;
        ctrl_t       ctrl;
        logic [4:0]  dest;
        logic [31:0] aluRes;    // Already holds PC+8 for jal
        logic [31:0] storeData;
    } emReg_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        instrWord_t  instr;
        ctrl_t       ctrl;
        logic [4:0]  dest;
        logic [31:0] aluRes;
        logic [31:0] loadData;
    } mwReg_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] datW;
        logic [3:0]  sel;
    } wbReq_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  regNum;
        logic [31:0] data;
    } retire_t;

endpackage

`default_nettype wire

//--- source/ifu.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_macros.svh"

module ifu (
    input  wire         clk,
    input  wire         rstN_i,
    input  wire         hold_i,
    input  wire [31:0]  nextPc_i,
    output logic [31:0] pc_o
);

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            pc_o <= `RESET_PC;
        end else if (!hold_i) begin // Load-use, branch wait or bus freeze
            pc_o <= nextPc_i;
        end
    end

endmodule

`default_nettype wire

//--- source/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_macros.svh"

module controlUnit import mipsPkg::*; (
    input  wire instrWord_t instr_i,
    output ctrl_t           ctrl_o
);

    always_comb begin
        ctrl_o = '0; // Nop unless recognised
        case (instr_i.iFmt.opcode)
            `OP_RTYPE: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.destSel  = DST_RD;
                case (instr_i.rFmt.funct)
                    `FN_ADDU: ctrl_o.aluOp = ALU_ADD;
                    `FN_SUBU: ctrl_o.aluOp = ALU_SUB;
                    `FN_AND:  ctrl_o.aluOp = ALU_AND;
                    `FN_OR:   ctrl_o.aluOp = ALU_OR;
                    `FN_SLT:  ctrl_o.aluOp = ALU_SLT;
                    `FN_SLL: begin
                        ctrl_o.aluOp       = ALU_SLL;
                        ctrl_o.aluSrcShamt = 1'b1;
                    end
                    `FN_JR: begin
                        ctrl_o.regWrite   = 1'b0;
                        ctrl_o.branchKind = BR_JR;
                    end
                    default: ctrl_o = '0;
                endcase
            end
            `OP_ORI: begin
                ctrl_o.aluOp     = ALU_OR;
                ctrl_o.aluSrcImm = 1'b1;  // Zero-extended
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.destSel   = DST_RT;
            end
            `OP_LUI: begin
                ctrl_o.aluOp     = ALU_LUI;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.destSel   = DST_RT;
            end
            `OP_LW: begin
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.extSigned = 1'b1;
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.destSel   = DST_RT;
                ctrl_o.wbSel     = WB_MEM;
                ctrl_o.memRead   = 1'b1;
            end
            `OP_SW: begin
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.extSigned = 1'b1;
                ctrl_o.memWrite  = 1'b1;
            end
            `OP_BEQ: begin
                ctrl_o.extSigned  = 1'b1;
                ctrl_o.branchKind = BR_BEQ;
            end
            `OP_BNE: begin
                ctrl_o.extSigned  = 1'b1;
                ctrl_o.branchKind = BR_BNE;
            end
            `OP_J:   ctrl_o.branchKind = BR_J;
            `OP_JAL: begin
                ctrl_o.branchKind = BR_JAL;
                ctrl_o.regWrite   = 1'b1;
                ctrl_o.destSel    = DST_RA;
                ctrl_o.wbSel      = WB_PC8; // Link is PC+8, past the delay slot
            end
            default: ctrl_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/regFile.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_macros.svh"

module regFile (
    input  wire         clk,
    input  wire         rstN_i,
    input  wire [4:0]   rdAddrA_i,
    input  wire [4:0]   rdAddrB_i,
    input  wire [4:0]   wrAddr_i,
    input  wire         wrEn_i,
    input  wire [31:0]  wrData_i,
    output logic [31:0] rdDataA_o,
    output logic [31:0] rdDataB_o
);

    logic [31:0] regs [`REG_COUNT];

    // $0 reads zero; a write in the same cycle passes straight through
    function automatic logic [31:0] readPort(input logic [4:0] addr);
        if (addr == 5'd0)
            return 32'd0;
        else if (wrEn_i && wrAddr_i == addr)
            return wrData_i;
        else
            return regs[addr];
    endfunction

    always_comb begin
        rdDataA_o = readPort(rdAddrA_i);
        rdDataB_o = readPort(rdAddrB_i);
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= 32'd0;
        end else if (wrEn_i && wrAddr_i != 5'd0) begin
            regs[wrAddr_i] <= wrData_i;
        end
    end

endmodule

`default_nettype wire

//--- source/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_macros.svh"

module hazardUnit import mipsPkg::*; (
    input  wire fdReg_t fd_i,
    input  wire deReg_t de_i,
    input  wire emReg_t em_i,
    input  wire mwReg_t mw_i,
    output logic        stall_o,
    output fwdSel_t     fwdDecA_o,
    output fwdSel_t     fwdDecB_o,
    output fwdSel_t     fwdExA_o,
    output fwdSel_t     fwdExB_o
);

    logic [5:0] opD;
    logic [4:0] rsD, rtD;
    logic       usesRs, usesRt, isBranch;
    logic       exHit, memLoadHit;

    function automatic logic writes(input logic valid, input ctrl_t ctrl,
                                    input logic [4:0] dest, input logic [4:0] src);
        return valid && ctrl.regWrite && dest == src && src != 5'd0;
    endfunction

    // Nearest stage first; loads are never taken from execute or memory
    function automatic fwdSel_t decSel(input logic [4:0] src);
        if (writes(de_i.valid, de_i.ctrl, de_i.dest, src) && !de_i.ctrl.memRead)
            return FWD_EX;
        else if (writes(em_i.valid, em_i.ctrl, em_i.dest, src) && !em_i.ctrl.memRead)
            return FWD_MEM;
        else if (writes(mw_i.valid, mw_i.ctrl, mw_i.dest, src))
            return FWD_WB;
        else
            return FWD_RF;
    endfunction

    function automatic fwdSel_t exSel(input logic [4:0] src);
        if (writes(em_i.valid, em_i.ctrl, em_i.dest, src) && !em_i.ctrl.memRead)
            return FWD_MEM;
        else if (writes(mw_i.valid, mw_i.ctrl, mw_i.dest, src))
            return FWD_WB;
        else
            return FWD_RF;
    endfunction

    assign opD = fd_i.instr.iFmt.opcode;
    assign rsD = fd_i.instr.iFmt.rs;
    assign rtD = fd_i.instr.iFmt.rt;

    // Conservative read sets, an extra stall is harmless
    assign usesRs   = !(opD == `OP_J || opD == `OP_JAL || opD == `OP_LUI);
    assign usesRt   = opD == `OP_RTYPE || opD == `OP_BEQ || opD == `OP_BNE || opD == `OP_SW;
    assign isBranch = opD == `OP_BEQ || opD == `OP_BNE
                      || (opD == `OP_RTYPE && fd_i.instr.rFmt.funct == `FN_JR);

    always_comb begin
        fwdDecA_o = decSel(rsD);
        fwdDecB_o = decSel(rtD);
        fwdExA_o  = exSel(de_i.instr.rFmt.rs);
        fwdExB_o  = exSel(de_i.instr.rFmt.rt);

        exHit = (usesRs && writes(de_i.valid, de_i.ctrl, de_i.dest, rsD))
                || (usesRt && writes(de_i.valid, de_i.ctrl, de_i.dest, rtD));
        memLoadHit = em_i.ctrl.memRead
                     && ((usesRs && writes(em_i.valid, em_i.ctrl, em_i.dest, rsD))
                         || (usesRt && writes(em_i.valid, em_i.ctrl, em_i.dest, rtD)));

        // Load-use, or compare operand not ready in decode
        stall_o = fd_i.valid && ((exHit && de_i.ctrl.memRead)
                                 || (isBranch && (exHit || memLoadHit)));
    end

endmodule

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import mipsPkg::*; (
    input  wire aluOp_t op_i,
    input  wire [31:0]  a_i,
    input  wire [31:0]  b_i,
    output logic [31:0] result_o
);

    always_comb begin
        case (op_i)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_SLT: result_o = {31'd0, $signed(a_i) < $signed(b_i)};
            ALU_SLL: result_o = b_i << a_i[4:0];   // A carries shamt
            ALU_LUI: result_o = {b_i[15:0], 16'd0};
            default: result_o = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/dataMemPort.sv
`timescale 1ns/1ps
`default_nettype none

module dataMemPort import mipsPkg::*; (
    input  wire         clk,
    input  wire         rstN_i,
    input  wire emReg_t em_i,
    output wbReq_t      wbReq_o,
    input  wire [31:0]  wbDatR_i,
    input  wire         wbAck_i,
    output logic [31:0] loadData_o,
    output logic        freeze_o
);

    typedef enum logic {IDLE, WAIT} busState_t;

    busState_t   state;
    logic        access;
    logic        weQ;
    logic [31:0] adrQ;
    logic [31:0] datQ;

    assign access = em_i.valid && (em_i.ctrl.memRead || em_i.ctrl.memWrite);

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (access) state <= WAIT;
                WAIT:    if (wbAck_i) state <= IDLE; // cyc drops next cycle
                default: state <= IDLE;
            endcase
        end
    end

    // Request fields latched once; em_i cannot move while frozen
    always_ff @(posedge clk) begin
        if (state == IDLE && access) begin
            weQ  <= em_i.ctrl.memWrite;
            adrQ <= {em_i.aluRes[31:2], 2'b00};
            datQ <= em_i.storeData;
        end
    end

    assign wbReq_o = '{cyc: state == WAIT, stb: state == WAIT, we: weQ,
                       adr: adrQ, datW: datQ, sel: 4'hf};

    // Pipeline advances on the ack edge and mw takes the read data then
    assign freeze_o   = access && !(state == WAIT && wbAck_i);
    assign loadData_o = wbDatR_i;

endmodule

`default_nettype wire

//--- source/mips.sv
`timescale 1ns/1ps
`default_nettype none

module mips import mipsPkg::*; (
    input  wire             clk,
    input  wire             rstN_i,
    output logic [31:0]     imemAddr_o,
    input  wire instrWord_t imemData_i,
    output wbReq_t          wbReq_o,
    input  wire [31:0]      wbDatR_i,
    input  wire             wbAck_i,
    output retire_t         retire_o
);

    fdReg_t      fd;
    deReg_t      de;
    emReg_t      em;
    mwReg_t      mw;
    logic        stall, freeze, hold, rfWrEn;
    logic [31:0] nextPc, pcPlus4D, branchOff, immD;
    logic [31:0] rfA, rfB, decA, decB;
    logic [4:0]  destD;
    logic [31:0] exA, exB, aluA, aluB, aluOut, exResult;
    logic [31:0] loadData, wbValue;
    ctrl_t       ctrlD, ctrlE;
    fwdSel_t     fwdDecA, fwdDecB, fwdExA, fwdExB;

    function automatic logic [31:0] fwdMux(input fwdSel_t sel, input logic [31:0] regV,
                                           input logic [31:0] exV, input logic [31:0] memV,
                                           input logic [31:0] wbV);
        case (sel)
            FWD_EX:  return exV;
            FWD_MEM: return memV;
            FWD_WB:  return wbV;
            default: return regV;
        endcase
    endfunction

    hazardUnit hazards (.fd_i(fd), .de_i(de), .em_i(em), .mw_i(mw), .stall_o(stall),
                        .fwdDecA_o(fwdDecA), .fwdDecB_o(fwdDecB),
                        .fwdExA_o(fwdExA), .fwdExB_o(fwdExB));

    assign hold = stall || freeze;

    ////////////////////////////////////////////////////////////
    // Fetch
    ifu fetch (.clk, .rstN_i, .hold_i(hold), .nextPc_i(nextPc), .pc_o(imemAddr_o));

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i)
            fd <= '0;
        else if (!hold)
            fd <= '{valid: 1'b1, pc: imemAddr_o, instr: imemData_i};
    end

    ////////////////////////////////////////////////////////////
    // Decode, with branches resolved here
    controlUnit decodeCtrl (.instr_i(fd.instr), .ctrl_o(ctrlD));

    regFile regs (.clk, .rstN_i, .rdAddrA_i(fd.instr.rFmt.rs), .rdAddrB_i(fd.instr.rFmt.rt),
                  .wrAddr_i(mw.dest), .wrEn_i(rfWrEn), .wrData_i(wbValue),
                  .rdDataA_o(rfA), .rdDataB_o(rfB));

    assign decA      = fwdMux(fwdDecA, rfA, exResult, em.aluRes, wbValue);
    assign decB      = fwdMux(fwdDecB, rfB, exResult, em.aluRes, wbValue);
    assign pcPlus4D  = fd.pc + 32'd4;
    assign branchOff = {{14{fd.instr.iFmt.imm[15]}}, fd.instr.iFmt.imm, 2'b00};
    assign immD      = ctrlD.extSigned ? {{16{fd.instr.iFmt.imm[15]}}, fd.instr.iFmt.imm}
                                       : {16'd0, fd.instr.iFmt.imm};

    always_comb begin
        case (ctrlD.destSel)
            DST_RT:  destD = fd.instr.rFmt.rt;
            DST_RA:  destD = 5'd31;
            default: destD = fd.instr.rFmt.rd;
        endcase
    end

    // Fetch already holds the delay slot, so targets replace PC+4 of the slot
    always_comb begin
        nextPc = imemAddr_o + 32'd4;
        if (fd.valid) begin
            case (ctrlD.branchKind)
                BR_BEQ:      if (decA == decB) nextPc = pcPlus4D + branchOff;
                BR_BNE:      if (decA != decB) nextPc = pcPlus4D + branchOff;
                BR_J, BR_JAL: nextPc = {pcPlus4D[31:28], fd.instr[25:0], 2'b00};
                BR_JR:       nextPc = decA;
                default:     ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            de <= '0;
        end else if (!freeze) begin
            if (stall || !fd.valid)
                de <= '0; // Bubble
            else
                de <= '{valid: 1'b1, pc: fd.pc, instr: fd.instr, ctrl: ctrlD,
                        opA: decA, opB: decB, imm: immD, dest: destD};
        end
    end

    ////////////////////////////////////////////////////////////
    // Execute
    controlUnit execCtrl (.instr_i(de.instr), .ctrl_o(ctrlE));

    assign exA  = fwdMux(fwdExA, de.opA, 32'd0, em.aluRes, wbValue);
    assign exB  = fwdMux(fwdExB, de.opB, 32'd0, em.aluRes, wbValue);
    assign aluA = ctrlE.aluSrcShamt ? {27'd0, de.instr.rFmt.shamt} : exA;
    assign aluB = ctrlE.aluSrcImm ? de.imm : exB;

    alu execAlu (.op_i(ctrlE.aluOp), .a_i(aluA), .b_i(aluB), .result_o(aluOut));

    assign exResult = (ctrlE.wbSel == WB_PC8) ? de.pc + 32'd8 : aluOut; // jal link

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i)
            em <= '0;
        else if (!freeze)
            em <= '{valid: de.valid, pc: de.pc, instr: de.instr, ctrl: ctrlE,
                    dest: de.dest, aluRes: exResult, storeData: exB};
    end

    ////////////////////////////////////////////////////////////
    // Memory
    dataMemPort dataPort (.clk, .rstN_i, .em_i(em), .wbReq_o, .wbDatR_i, .wbAck_i,
                          .loadData_o(loadData), .freeze_o(freeze));

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i)
            mw <= '0;
        else if (!freeze)
            mw <= '{valid: em.valid, pc: em.pc, instr: em.instr, ctrl: em.ctrl,
                    dest: em.dest, aluRes: em.aluRes, loadData: loadData};
    end

    ////////////////////////////////////////////////////////////
    // Writeback and retire trace
    assign wbValue = (mw.ctrl.wbSel == WB_MEM) ? mw.loadData : mw.aluRes;
    assign rfWrEn  = mw.valid && mw.ctrl.regWrite && !freeze; // Commits once, after freeze

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i)
            retire_o <= '0;
        else
            retire_o <= '{valid: rfWrEn && mw.dest != 5'd0, pc: mw.pc,
                          regNum: mw.dest, data: wbValue};
    end

endmodule

`default_nettype wire

//--- test/mips_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module mips_assertions import mipsPkg::*; (
    input wire          clk,
    input wire          rstN_i,
    input wire wbReq_t  wbReq_i,
    input wire          wbAck_i,
    input wire retire_t retire_i
);

    // Strobe only inside a bus cycle
    stbInCyc: assert property (@(posedge clk) disable iff (!rstN_i)
        wbReq_i.stb |-> wbReq_i.cyc)
        else $error("Wishbone stb is high while cyc is low");

    reqStable: assert property (@(posedge clk) disable iff (!rstN_i)
        wbReq_i.cyc && !wbAck_i |=> $stable(wbReq_i))  // Held until ack
        else $error("Wishbone request changed before it was acknowledged");

    // The pipeline is frozen while a bus cycle waits for ack
    noRetireInFreeze: assert property (@(posedge clk) disable iff (!rstN_i)
        retire_i.valid |-> !$past(wbReq_i.cyc && !wbAck_i))
        else $error("Register write retired during a memory freeze");

endmodule

bind mips mips_assertions busChecks (.clk(clk), .rstN_i(rstN_i), .wbReq_i(wbReq_o),
                                     .wbAck_i(wbAck_i), .retire_i(retire_o));

`default_nettype wire

//--- test/mips_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_macros.svh"

module mips_tb import mipsPkg::*; ();

    localparam int PROG_LEN       = 200;
    localparam int TERM_IDX       = 190;  // Branch-to-self
    localparam int LEAF_IDX       = 192;  // jal target ending in jr $31
    localparam int TIMEOUT_CYCLES = PROG_LEN * 8 + 100;

    logic        clk;
    logic        rstN_i;
    logic [31:0] imemAddr;
    logic [31:0] fetchOff;
    instrWord_t  imemData;
    wbReq_t      wbReq;
    logic [31:0] wbDatR_i;
    logic        wbAck_i;
    retire_t     retire;

    instrWord_t  prog [256];
    logic [31:0] slaveMem [64];
    int unsigned ackWaits [256];
    retire_t     expRetire [$];
    wbReq_t      expBus [$];
    int          retCnt = 0;
    int          busCnt = 0;
    int          cyclesOut = 0;

    mips dut_i (.clk(clk), .rstN_i(rstN_i), .imemAddr_o(imemAddr), .imemData_i(imemData),
                .wbReq_o(wbReq), .wbDatR_i(wbDatR_i), .wbAck_i(wbAck_i), .retire_o(retire));

    // Combinational instruction port
    assign fetchOff = imemAddr - `RESET_PC;
    assign imemData = prog[fetchOff[9:2]];  // Words past the program read as nop

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks
    task automatic failRun(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkRetire(input string name, input retire_t exp, input retire_t act);
        if (act !== exp)
            failRun($sformatf("Fail %s expected pc %h r%0d = %h actual pc %h r%0d = %h (valid %b)",
                              name, exp.pc, exp.regNum, exp.data,
                              act.pc, act.regNum, act.data, act.valid));
    endtask

    // Write data only matters for stores
    task automatic checkBus(input string name, input wbReq_t exp, input wbReq_t act);
        if (act.cyc !== exp.cyc || act.stb !== exp.stb || act.we !== exp.we
            || act.adr !== exp.adr || act.sel !== exp.sel
            || (exp.we && act.datW !== exp.datW))
            failRun($sformatf("Fail %s expected we %b adr %h dat %h actual we %b adr %h dat %h",
                              name, exp.we, exp.adr, exp.datW, act.we, act.adr, act.datW));
    endtask

    ////////////////////////////////////////////////////////////
    // Program generation
    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], ~addr[15:0]};
    endfunction

    function automatic logic [4:0] pickReg();
        return 5'($urandom_range(15, 0));  // $31 stays reserved for jal
    endfunction

    function automatic instrWord_t rInstr(input logic [5:0] funct, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] shamt);
        instrWord_t w;
        w.rFmt = '{opcode: `OP_RTYPE, rs: rs, rt: rt, rd: rd, shamt: shamt, funct: funct};
        return w;
    endfunction

    function automatic instrWord_t iInstr(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        instrWord_t w;
        w.iFmt = '{opcode: op, rs: rs, rt: rt, imm: imm};
        return w;
    endfunction

    function automatic instrWord_t jInstr(input logic [5:0] op, input int idx);
        logic [31:0] dest;
        dest = `RESET_PC + 32'(idx) * 4;
        return {op, dest[27:2]};
    endfunction

    // Any instruction that is not a branch or jump
    function automatic instrWord_t plainInstr();
        logic [15:0] wordOff;
        wordOff = 16'($urandom_range(63, 0) * 4);  // 64-word window from $0
        case ($urandom_range(9, 0))
            0, 1, 2, 3, 4: begin
                case ($urandom_range(5, 0))
                    0: return rInstr(`FN_ADDU, pickReg(), pickReg(), pickReg(), 5'd0);
                    1: return rInstr(`FN_SUBU, pickReg(), pickReg(), pickReg(), 5'd0);
                    2: return rInstr(`FN_AND, pickReg(), pickReg(), pickReg(), 5'd0);
                    3: return rInstr(`FN_OR, pickReg(), pickReg(), pickReg(), 5'd0);
                    4: return rInstr(`FN_SLT, pickReg(), pickReg(), pickReg(), 5'd0);
                    default: return rInstr(`FN_SLL, 5'd0, pickReg(), pickReg(),
                                           5'($urandom_range(31, 0)));
                endcase
            end
            5:       return iInstr(`OP_ORI, pickReg(), pickReg(), 16'($urandom));
            6:       return iInstr(`OP_LUI, 5'd0, pickReg(), 16'($urandom));
            7, 8:    return iInstr(`OP_LW, 5'd0, pickReg(), wordOff);
            default: return iInstr(`OP_SW, 5'd0, pickReg(), wordOff);
        endcase
    endfunction

    function automatic void buildProgram();
        int  pick;
        int  off;
        logic lastCtrl;
        for (int i = 0; i < 256; i++)
            prog[i] = '0;
        prog[0]  = iInstr(`OP_LUI, 5'd0, 5'd1, 16'($urandom));
        lastCtrl = 1'b0;
        for (int i = 1; i < TERM_IDX; i++) begin
            pick = $urandom_range(99, 0);
            if (lastCtrl || i > TERM_IDX - 3 || pick < 74) begin
                prog[i]  = plainInstr();  // Also every delay slot
                lastCtrl = 1'b0;
            end else begin
                off = $urandom_range(5, 1);
                if (off > TERM_IDX - 1 - i)
                    off = TERM_IDX - 1 - i;
                if (pick < 86)
                    prog[i] = iInstr(pick[0] ? `OP_BNE : `OP_BEQ, pickReg(), pickReg(),
                                     16'(off));
                else if (pick < 92)
                    prog[i] = jInstr(`OP_J, i + 1 + off);
                else
                    prog[i] = jInstr(`OP_JAL, LEAF_IDX);
                lastCtrl = 1'b1;
            end
        end
        prog[TERM_IDX] = iInstr(`OP_BEQ, 5'd0, 5'd0, 16'hffff);
        for (int i = LEAF_IDX; i < LEAF_IDX + 6; i++)
            prog[i] = plainInstr();
        prog[LEAF_IDX + 6] = rInstr(`FN_JR, 5'd31, 5'd0, 5'd0, 5'd0);
        prog[LEAF_IDX + 7] = plainInstr();
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference model stepping one instruction at a time with delay slots
    function automatic void runReference();
        logic [31:0] regs [32];
        logic [31:0] mem [64];
        logic [31:0] pc, npc, target, addr, res, sext, off, a, b;
        instrWord_t  ins;
        logic        taken, wr;
        logic [4:0]  dst;
        retire_t     rec;
        wbReq_t      req;
        int          steps;
        for (int i = 0; i < 32; i++)
            regs[i] = 32'd0;
        for (int i = 0; i < 64; i++)
            mem[i] = fillWord(32'(i * 4));
        pc    = `RESET_PC;
        npc   = pc + 32'd4;
        steps = 0;
        while (pc != `RESET_PC + TERM_IDX * 4 && steps < 4000) begin
            off   = pc - `RESET_PC;
            ins   = prog[off[9:2]];
            a     = regs[ins.rFmt.rs];
            b     = regs[ins.rFmt.rt];
            sext  = {{16{ins.iFmt.imm[15]}}, ins.iFmt.imm};
            addr  = a + sext;
            req   = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: {addr[31:2], 2'b00},
                      datW: 32'd0, sel: 4'hf};
            taken = 1'b0;
            wr    = 1'b1;
            dst   = ins.iFmt.rt;
            res   = 32'd0;
            target = 32'd0;
            case (ins.iFmt.opcode)
                `OP_RTYPE: begin
                    dst = ins.rFmt.rd;
                    case (ins.rFmt.funct)
                        `FN_ADDU: res = a + b;
                        `FN_SUBU: res = a - b;
                        `FN_AND:  res = a & b;
                        `FN_OR:   res = a | b;
                        `FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
                        `FN_SLL:  res = b << ins.rFmt.shamt;
                        default: begin  // jr
                            wr     = 1'b0;
                            taken  = 1'b1;
                            target = a;
                        end
                    endcase
                end
                `OP_ORI: res = a | {16'd0, ins.iFmt.imm};
                `OP_LUI: res = {ins.iFmt.imm, 16'd0};
                `OP_LW: begin
                    res = mem[addr[7:2]];
                    expBus.push_back(req);
                end
                `OP_SW: begin
                    wr = 1'b0;
                    mem[addr[7:2]] = b;
                    req.we   = 1'b1;
                    req.datW = b;
                    expBus.push_back(req);
                end
                `OP_BEQ, `OP_BNE: begin
                    wr     = 1'b0;
                    taken  = (a == b) == (ins.iFmt.opcode == `OP_BEQ);
                    target = pc + 32'd4 + {sext[29:0], 2'b00};
                end
                default: begin  // j and jal
                    wr     = ins.iFmt.opcode == `OP_JAL;
                    dst    = 5'd31;
                    res    = pc + 32'd8;
                    taken  = 1'b1;
                    target = {npc[31:28], ins[25:0], 2'b00};
                end
            endcase
            if (wr && dst != 5'd0) begin
                regs[dst] = res;
                rec = '{valid: 1'b1, pc: pc, regNum: dst, data: res};
                expRetire.push_back(rec);
            end
            pc  = npc;
            npc = taken ? target : npc + 32'd4;
            steps++;
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        rstN_i = 1'b0;
        void'($urandom(32'h3554b88f));
        buildProgram();
        for (int i = 0; i < 64; i++)
            slaveMem[i] = fillWord(32'(i * 4));
        for (int i = 0; i < 256; i++)
            ackWaits[i] = $urandom_range(3, 0);
        runReference();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstN_i = 1'b1;
        while (retCnt < expRetire.size() || busCnt < expBus.size())
            @(posedge clk);
        repeat (20) @(posedge clk);  // Catch anything extra
        $display("all tests passed");
        $finish;
    end

    // Wishbone slave with 0 to 3 wait cycles
    initial begin
        logic        busy;
        int unsigned waitLeft;
        int          xferIdx;
        wbAck_i  = 1'b0;
        wbDatR_i = 32'd0;
        busy     = 1'b0;
        waitLeft = 0;
        xferIdx  = 0;
        forever begin
            @(negedge clk);
            if (wbAck_i) begin
                wbAck_i = 1'b0;
                busy    = 1'b0;
            end else if (rstN_i && wbReq.cyc && wbReq.stb) begin
                if (!busy) begin
                    busy     = 1'b1;
                    waitLeft = ackWaits[xferIdx % 256];
                    xferIdx++;
                end
                if (waitLeft == 0) begin
                    if (wbReq.we)
                        slaveMem[wbReq.adr[7:2]] = wbReq.datW;
                    else
                        wbDatR_i = slaveMem[wbReq.adr[7:2]];
                    wbAck_i = 1'b1;
                end else begin
                    waitLeft--;
                end
            end
        end
    end

    // Compare process sees the values from before the edge
    always @(posedge clk) begin
        if (rstN_i) begin
            cyclesOut++;
            if (cyclesOut <= 4 && (wbReq.cyc || retire.valid))
                failRun("Bus cycle or retire seen before the first instruction reached writeback");
            if (imemAddr[1:0] !== 2'b00 || fetchOff >= 32'(PROG_LEN * 4))
                failRun($sformatf("Fetch address %h lies outside the program", imemAddr));
            if (retire.valid) begin
                if (retCnt >= expRetire.size()) begin
                    failRun("Retire seen after the last expected register write");
                end else begin
                    checkRetire($sformatf("retire %0d", retCnt), expRetire[retCnt], retire);
                    retCnt++;
                end
            end
            if (wbReq.cyc && wbReq.stb && wbAck_i) begin
                if (busCnt >= expBus.size()) begin
                    failRun("Bus transfer seen after the last expected load or store");
                end else begin
                    checkBus($sformatf("bus %0d", busCnt), expBus[busCnt], wbReq);
                    busCnt++;
                end
            end
        end
    end

    initial begin
        wait (rstN_i === 1'b1);
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        failRun("Timeout: not all expected retires and bus transfers arrived");
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+source
source/mipsPkg.sv
source/ifu.sv
source/controlUnit.sv
source/regFile.sv
source/hazardUnit.sv
source/alu.sv
source/dataMemPort.sv
source/mips.sv
test/mips_assertions.sv
test/mips_tb.sv
